//--- hdl/core_side_pkg.sv
// ####################
// Core side of the memory scheduler
// Lane widths and request/response structs
// ####################

package core_side_pkg;

    localparam int NUM_LANES      = 4;
    localparam int WORD_WIDTH     = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int ADDR_WIDTH     = 30;
    localparam int CORE_TAG_WIDTH = 8;

    typedef struct packed {
        logic                                          rw;
        logic [NUM_LANES-1:0]                          mask;
        logic [NUM_LANES-1:0][BYTES_PER_WORD-1:0]      byteen;
        logic [NUM_LANES-1:0][ADDR_WIDTH-1:0]          addr;
        logic [NUM_LANES-1:0][WORD_WIDTH-1:0]          data;
        logic [CORE_TAG_WIDTH-1:0]                     tag;
    } core_req_t;

    typedef struct packed {
        logic [NUM_LANES-1:0]                          mask;
        logic [NUM_LANES-1:0][WORD_WIDTH-1:0]          data;
        logic [CORE_TAG_WIDTH-1:0]                     tag;
    } core_rsp_t;

endpackage

//--- hdl/mem_side_pkg.sv
// ####################
// Memory side of the scheduler
// Channel widths, tag layout and memory structs
// ####################

package mem_side_pkg;

    import core_side_pkg::*;

    localparam int MEM_CHANNELS = 2;
    localparam int NUM_BATCHES  = NUM_LANES / MEM_CHANNELS;
    localparam int BATCH_BITS   = 1;
    // Widest slot index allows up to 8 slots
    localparam int SLOT_BITS    = 3;

    typedef struct packed {
        logic [SLOT_BITS-1:0]  slot;
        logic [BATCH_BITS-1:0] batch;
    } mem_tag_t;

    // Core request with its tag swapped for a slot number
    typedef struct packed {
        logic                                     rw;
        logic [NUM_LANES-1:0]                     mask;
        logic [NUM_LANES-1:0][BYTES_PER_WORD-1:0] byteen;
        logic [NUM_LANES-1:0][ADDR_WIDTH-1:0]     addr;
        logic [NUM_LANES-1:0][WORD_WIDTH-1:0]     data;
        logic [SLOT_BITS-1:0]                     slot;
    } queued_req_t;

    typedef struct packed {
        logic [MEM_CHANNELS-1:0]                     mask;
        logic                                        rw;
        logic [MEM_CHANNELS-1:0][BYTES_PER_WORD-1:0] byteen;
        logic [MEM_CHANNELS-1:0][ADDR_WIDTH-1:0]     addr;
        logic [MEM_CHANNELS-1:0][WORD_WIDTH-1:0]     data;
        mem_tag_t                                    tag;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_CHANNELS-1:0]                 mask;
        logic [MEM_CHANNELS-1:0][WORD_WIDTH-1:0] data;
        mem_tag_t                                tag;
    } mem_rsp_t;

endpackage

//--- hdl/elastic_fifo.sv
// ####################
// Elastic FIFO with a registered output stage
// ####################

`timescale 1ns/1ps

module elastic_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] buf_count;
    logic             push;
    logic             load;
    logic             from_buf;
    logic             bypass;
    logic             to_buf;

    assign push     = in_valid && in_ready;
    // Output register is free or drains this cycle
    assign load     = ~out_valid || out_ready;
    assign from_buf = load && (buf_count != '0);
    assign bypass   = load && (buf_count == '0) && push;
    assign to_buf   = push && ~bypass;
    // Output stage counts toward capacity
    assign in_ready = (buf_count + CNT_W'(out_valid)) < CNT_W'(DEPTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            buf_count <= '0;
            out_valid <= 1'b0;
        end else begin
            if (to_buf)
                wr_ptr <= wr_ptr + PTR_W'(1);
            if (from_buf)
                rd_ptr <= rd_ptr + PTR_W'(1);
            buf_count <= buf_count + CNT_W'(to_buf) - CNT_W'(from_buf);
            if (load)
                out_valid <= from_buf || bypass;
        end
    end

    always_ff @(posedge clk) begin
        if (to_buf)
            mem[wr_ptr] <= in_data;
        if (from_buf)
            out_data <= mem[rd_ptr];
        else if (bypass)
            out_data <= in_data;
    end

endmodule

//--- hdl/tag_slot_table.sv
// ####################
// Read slot table that hands out free slots
// and keeps the core tag of each pending read
// ####################

`timescale 1ns/1ps

module tag_slot_table
    import core_side_pkg::*;
    import mem_side_pkg::*;
#(
    parameter int QUEUE_SIZE = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      alloc,
    input  logic [CORE_TAG_WIDTH-1:0] alloc_tag,
    output logic [SLOT_BITS-1:0]      alloc_slot,
    input  logic                      release_en,
    input  logic [SLOT_BITS-1:0]      lookup_slot,
    output logic [CORE_TAG_WIDTH-1:0] lookup_tag,
    output logic                      full,
    output logic                      empty
);
    localparam int IDX_W = $clog2(QUEUE_SIZE);

    logic [QUEUE_SIZE-1:0]     used_r;
    logic [CORE_TAG_WIDTH-1:0] tags_r [QUEUE_SIZE];

    // Lowest free slot wins
    always_comb begin
        alloc_slot = '0;
        for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!used_r[i])
                alloc_slot = SLOT_BITS'(i);
        end
    end

    assign full       = &used_r;
    assign empty      = ~|used_r;
    assign lookup_tag = tags_r[lookup_slot[IDX_W-1:0]];

    // Alloc takes a free slot and release a used one, so they never collide
    always_ff @(posedge clk) begin
        if (reset) begin
            used_r <= '0;
        end else begin
            if (alloc)
                used_r[alloc_slot[IDX_W-1:0]] <= 1'b1;
            if (release_en)
                used_r[lookup_slot[IDX_W-1:0]] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc)
            tags_r[alloc_slot[IDX_W-1:0]] <= alloc_tag;
    end

endmodule

//--- hdl/batch_sequencer.sv
// ####################
// Splits a queued request into
// memory channel batches
// ####################

`timescale 1ns/1ps

module batch_sequencer
    import core_side_pkg::*;
    import mem_side_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  queued_req_t in_req,
    output logic        out_valid,
    input  logic        out_ready,
    output mem_req_t    out_req
);
    logic [NUM_BATCHES-1:0][MEM_CHANNELS-1:0]                     batch_mask;
    logic [NUM_BATCHES-1:0][MEM_CHANNELS-1:0][BYTES_PER_WORD-1:0] batch_byteen;
    logic [NUM_BATCHES-1:0][MEM_CHANNELS-1:0][ADDR_WIDTH-1:0]     batch_addr;
    logic [NUM_BATCHES-1:0][MEM_CHANNELS-1:0][WORD_WIDTH-1:0]     batch_data;
    logic [BATCH_BITS-1:0] batch_idx_r;
    logic [BATCH_BITS-1:0] last_batch;
    logic                  cur_empty;
    logic                  step;
    logic                  is_last;

    // Lane b*MEM_CHANNELS+c goes to channel c of batch b
    always_comb begin
        for (int b = 0; b < NUM_BATCHES; b++) begin
            for (int c = 0; c < MEM_CHANNELS; c++) begin
                batch_mask[b][c]   = in_req.mask[b * MEM_CHANNELS + c];
                batch_byteen[b][c] = in_req.byteen[b * MEM_CHANNELS + c];
                batch_addr[b][c]   = in_req.addr[b * MEM_CHANNELS + c];
                batch_data[b][c]   = in_req.data[b * MEM_CHANNELS + c];
            end
        end
    end

    // Highest batch with any lane set
    always_comb begin
        last_batch = '0;
        for (int b = 0; b < NUM_BATCHES; b++) begin
            if (|batch_mask[b])
                last_batch = BATCH_BITS'(b);
        end
    end

    assign cur_empty = ~|batch_mask[batch_idx_r];
    assign out_valid = in_valid && ~cur_empty;
    // Empty batches are consumed without a transfer
    assign step      = in_valid && (cur_empty || out_ready);
    assign is_last   = (batch_idx_r == last_batch);
    assign in_ready  = step && is_last;

    always_comb begin
        out_req.mask      = batch_mask[batch_idx_r];
        out_req.rw        = in_req.rw;
        out_req.byteen    = batch_byteen[batch_idx_r];
        out_req.addr      = batch_addr[batch_idx_r];
        out_req.data      = batch_data[batch_idx_r];
        out_req.tag.slot  = in_req.slot;
        out_req.tag.batch = batch_idx_r;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_idx_r <= '0;
        end else if (step) begin
            if (is_last)
                batch_idx_r <= '0;
            else
                batch_idx_r <= batch_idx_r + BATCH_BITS'(1);
        end
    end

endmodule

//--- hdl/rsp_assembler.sv
// ####################
// Gathers memory responses per slot
// into one core response
// ####################

`timescale 1ns/1ps

module rsp_assembler
    import core_side_pkg::*;
    import mem_side_pkg::*;
#(
    parameter int QUEUE_SIZE = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      alloc,
    input  logic [SLOT_BITS-1:0]      alloc_slot,
    input  logic [NUM_LANES-1:0]      alloc_mask,
    input  logic                      mem_rsp_valid,
    output logic                      mem_rsp_ready,
    input  mem_rsp_t                  mem_rsp,
    input  logic [CORE_TAG_WIDTH-1:0] lookup_tag,
    output logic                      release_en,
    output logic                      core_rsp_valid,
    input  logic                      core_rsp_ready,
    output core_rsp_t                 core_rsp
);
    localparam int IDX_W = $clog2(QUEUE_SIZE);

    logic [NUM_LANES-1:0]                 orig_mask_r [QUEUE_SIZE];
    logic [NUM_LANES-1:0]                 rem_mask_r  [QUEUE_SIZE];
    logic [NUM_LANES-1:0][WORD_WIDTH-1:0] data_r      [QUEUE_SIZE];
    logic [IDX_W-1:0]                     rsp_slot;
    logic [IDX_W-1:0]                     new_slot;
    logic [NUM_LANES-1:0]                 cur_mask;
    logic [NUM_LANES-1:0]                 rem_next;
    logic [NUM_LANES-1:0][WORD_WIDTH-1:0] data_next;
    logic                                 complete;
    logic                                 rsp_fire;

    assign rsp_slot = mem_rsp.tag.slot[IDX_W-1:0];
    assign new_slot = alloc_slot[IDX_W-1:0];

    // Core lanes covered by this batch
    always_comb begin
        for (int r = 0; r < NUM_LANES; r++) begin
            cur_mask[r] = (mem_rsp.tag.batch == BATCH_BITS'(r / MEM_CHANNELS))
                          && mem_rsp.mask[r % MEM_CHANNELS];
        end
    end

    always_comb begin
        data_next = data_r[rsp_slot];
        for (int r = 0; r < NUM_LANES; r++) begin
            if (cur_mask[r])
                data_next[r] = mem_rsp.data[r % MEM_CHANNELS];
        end
    end

    assign rem_next = rem_mask_r[rsp_slot] & ~cur_mask;
    assign complete = ~|rem_next;

    // Stall only a completing response the core cannot take
    assign mem_rsp_ready  = core_rsp_ready || ~complete;
    assign rsp_fire       = mem_rsp_valid && mem_rsp_ready;
    assign core_rsp_valid = mem_rsp_valid && complete;
    assign release_en     = core_rsp_valid && core_rsp_ready;

    assign core_rsp.mask = orig_mask_r[rsp_slot];
    assign core_rsp.data = data_next;
    assign core_rsp.tag  = lookup_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            rem_mask_r <= '{default: '0};
        end else begin
            if (alloc)
                rem_mask_r[new_slot] <= alloc_mask;
            if (rsp_fire)
                rem_mask_r[rsp_slot] <= rem_next;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc)
            orig_mask_r[new_slot] <= alloc_mask;
        if (rsp_fire)
            data_r[rsp_slot] <= data_next;
    end

endmodule

//--- hdl/mem_scheduler.sv
// ####################
// Memory request scheduler top level
// Queues core requests, batches them to memory, reassembles responses
// ####################

`timescale 1ns/1ps

module mem_scheduler
    import core_side_pkg::*;
    import mem_side_pkg::*;
#(
    parameter int QUEUE_SIZE    = 4,
    parameter int MEM_BUF_DEPTH = 2
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      core_req_valid,
    output logic      core_req_ready,
    input  core_req_t core_req,
    output logic      core_rsp_valid,
    input  logic      core_rsp_ready,
    output core_rsp_t core_rsp,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output mem_req_t  mem_req,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready,
    input  mem_rsp_t  mem_rsp,
    output logic      idle
);
    queued_req_t               qreq_in;
    queued_req_t               qreq_out;
    logic                      reqq_in_ready;
    logic                      reqq_out_valid;
    logic                      reqq_out_ready;
    mem_req_t                  seq_req;
    logic                      seq_valid;
    logic                      seq_ready;
    logic                      slot_ok;
    logic                      alloc;
    logic                      release_en;
    logic                      slots_full;
    logic                      slots_empty;
    logic [SLOT_BITS-1:0]      alloc_slot;
    logic [CORE_TAG_WIDTH-1:0] lookup_tag;

    // Reads need a free slot, writes only need queue room
    assign slot_ok        = core_req.rw || ~slots_full;
    assign core_req_ready = reqq_in_ready && slot_ok;
    assign alloc          = core_req_valid && core_req_ready && ~core_req.rw;
    assign idle           = ~reqq_out_valid && slots_empty;

    assign qreq_in.rw     = core_req.rw;
    assign qreq_in.mask   = core_req.mask;
    assign qreq_in.byteen = core_req.byteen;
    assign qreq_in.addr   = core_req.addr;
    assign qreq_in.data   = core_req.data;
    assign qreq_in.slot   = alloc_slot;

    elastic_fifo #(.payload_t(queued_req_t), .DEPTH(QUEUE_SIZE)) req_queue (
        .clk(clk), .reset(reset),
        .in_valid(core_req_valid && slot_ok), .in_ready(reqq_in_ready), .in_data(qreq_in),
        .out_valid(reqq_out_valid), .out_ready(reqq_out_ready), .out_data(qreq_out)
    );

    tag_slot_table #(.QUEUE_SIZE(QUEUE_SIZE)) slot_table (
        .clk(clk), .reset(reset),
        .alloc(alloc), .alloc_tag(core_req.tag), .alloc_slot(alloc_slot),
        .release_en(release_en), .lookup_slot(mem_rsp.tag.slot), .lookup_tag(lookup_tag),
        .full(slots_full), .empty(slots_empty)
    );

    batch_sequencer sequencer (
        .clk(clk), .reset(reset),
        .in_valid(reqq_out_valid), .in_ready(reqq_out_ready), .in_req(qreq_out),
        .out_valid(seq_valid), .out_ready(seq_ready), .out_req(seq_req)
    );

    elastic_fifo #(.payload_t(mem_req_t), .DEPTH(MEM_BUF_DEPTH)) mem_req_buf (
        .clk(clk), .reset(reset),
        .in_valid(seq_valid), .in_ready(seq_ready), .in_data(seq_req),
        .out_valid(mem_req_valid), .out_ready(mem_req_ready), .out_data(mem_req)
    );

    rsp_assembler #(.QUEUE_SIZE(QUEUE_SIZE)) assembler (
        .clk(clk), .reset(reset),
        .alloc(alloc), .alloc_slot(alloc_slot), .alloc_mask(core_req.mask),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_ready(mem_rsp_ready), .mem_rsp(mem_rsp),
        .lookup_tag(lookup_tag), .release_en(release_en),
        .core_rsp_valid(core_rsp_valid), .core_rsp_ready(core_rsp_ready), .core_rsp(core_rsp)
    );

endmodule

//--- bench/mem_scheduler_asserts.sv
// ####################
// Protocol checks bound into the memory scheduler
// ####################

`timescale 1ns/1ps

module mem_scheduler_asserts
    import core_side_pkg::*;
    import mem_side_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      mem_req_valid,
    input logic      mem_req_ready,
    input mem_req_t  mem_req,
    input logic      core_rsp_valid,
    input core_rsp_t core_rsp
);
    int fail_count = 0;

    // A stalled memory request keeps its payload
    req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin
        $error("mem_req dropped or changed while stalled");
        fail_count++;
    end

    req_mask: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> |mem_req.mask)
    else begin
        $error("mem_req_valid with an empty lane mask");
        fail_count++;
    end

    rsp_mask: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid |-> |core_rsp.mask)
    else begin
        $error("core_rsp_valid with an empty lane mask");
        fail_count++;
    end

endmodule

bind mem_scheduler mem_scheduler_asserts protocol_chk (
    .clk(clk), .reset(reset),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_req(mem_req),
    .core_rsp_valid(core_rsp_valid), .core_rsp(core_rsp)
);

//--- bench/mem_scheduler_tb.sv
// ####################
// Testbench for the memory scheduler
// Memory model, directed tests, timeout
// ####################

`timescale 1ns/1ps

module mem_scheduler_tb
    import core_side_pkg::*;
    import mem_side_pkg::*;
();
    localparam int QUEUE_SIZE = 4;
    // Tests need roughly 600 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic      clk;
    logic      reset;
    logic      core_req_valid;
    logic      core_req_ready;
    core_req_t core_req;
    logic      core_rsp_valid;
    logic      core_rsp_ready;
    core_rsp_t core_rsp;
    logic      mem_req_valid;
    logic      mem_req_ready;
    mem_req_t  mem_req;
    logic      mem_rsp_valid;
    logic      mem_rsp_ready;
    mem_rsp_t  mem_rsp;
    logic      idle;

    integer      seed = 32'hffa39b56;
    int          cycles = 0;
    logic [31:0] mem_words [64];
    mem_rsp_t    pend_q [$];
    mem_req_t    req_log [$];
    core_rsp_t   rsp_log [$];

    mem_scheduler #(.QUEUE_SIZE(QUEUE_SIZE), .MEM_BUF_DEPTH(2)) UUT (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [29:0] addr);
        return 32'hc0de_0000 + 32'(addr[5:0]) * 32'h0001_0101;
    endfunction

    function automatic logic [31:0] write_word(input logic [29:0] addr);
        return 32'h5eed_0000 ^ (32'(addr[5:0]) << 8) ^ 32'(addr[5:0]);
    endfunction

    // Writes land at once and reads wait for a test to answer them
    always @(posedge clk) begin : mem_model
        mem_rsp_t rsp;
        if (!reset && mem_req_valid && mem_req_ready) begin
            req_log.push_back(mem_req);
            if (mem_req.rw) begin
                for (int c = 0; c < MEM_CHANNELS; c++)
                    for (int b = 0; b < BYTES_PER_WORD; b++)
                        if (mem_req.mask[c] && mem_req.byteen[c][b])
                            mem_words[mem_req.addr[c][5:0]][8*b +: 8] = mem_req.data[c][8*b +: 8];
            end else begin
                rsp = '0;
                rsp.mask = mem_req.mask;
                rsp.tag  = mem_req.tag;
                for (int c = 0; c < MEM_CHANNELS; c++)
                    if (mem_req.mask[c])
                        rsp.data[c] = mem_words[mem_req.addr[c][5:0]];
                pend_q.push_back(rsp);
            end
        end
    end

    always @(negedge clk)
        mem_req_ready = ($random(seed) & 3) != 0;

    always @(posedge clk) begin
        if (!reset && core_rsp_valid && core_rsp_ready)
            rsp_log.push_back(core_rsp);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $fatal(1, "timeout");
        end else if (UUT.protocol_chk.fail_count != 0) begin
            $display("a protocol assertion failed at %0t ns", $time);
            $display("sim failed");
            $fatal(1, "protocol assertion");
        end
    end

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        assert (got === exp) else begin
            $display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic core_req_t make_req(input logic rw, input logic [3:0] mask,
                                           input logic [29:0] base, input logic [7:0] tag);
        core_req_t req;
        req      = '0;
        req.rw   = rw;
        req.mask = mask;
        req.tag  = tag;
        for (int l = 0; l < NUM_LANES; l++) begin
            req.byteen[l] = 4'hf;
            req.addr[l]   = base + 30'(l);
            req.data[l]   = write_word(base + 30'(l));
        end
        return req;
    endfunction

    task automatic present_req(input core_req_t req);
        @(negedge clk);
        core_req       = req;
        core_req_valid = 1'b1;
    endtask

    task automatic await_req_accept();
        do @(posedge clk); while (!core_req_ready);
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    task automatic issue_req(input logic rw, input logic [3:0] mask,
                             input logic [29:0] base, input logic [7:0] tag);
        present_req(make_req(rw, mask, base, tag));
        await_req_accept();
    endtask

    task automatic wait_pending(input int n);
        while (pend_q.size() < n) @(negedge clk);
    endtask

    task automatic present_rsp(input int idx);
        mem_rsp_t rsp;
        rsp = pend_q[idx];
        pend_q.delete(idx);
        @(negedge clk);
        mem_rsp       = rsp;
        mem_rsp_valid = 1'b1;
    endtask

    task automatic finish_rsp();
        do @(posedge clk); while (!mem_rsp_ready);
        @(negedge clk);
        mem_rsp_valid = 1'b0;
    endtask

    task automatic answer(input int idx);
        present_rsp(idx);
        finish_rsp();
    endtask

    task automatic expect_rsp(input logic [3:0] mask, input logic [7:0] tag,
                              input logic [29:0] base, input bit written);
        core_rsp_t   rsp;
        logic [31:0] exp;
        while (rsp_log.size() == 0) @(negedge clk);
        rsp = rsp_log.pop_front();
        check_val("core_rsp.mask", rsp.mask, mask);
        check_val("core_rsp.tag", rsp.tag, tag);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (mask[l]) begin
                exp = written ? write_word(base + 30'(l)) : fill_word(base + 30'(l));
                check_val($sformatf("core_rsp.data[%0d]", l), rsp.data[l], exp);
            end
        end
    endtask

    task automatic write_then_read();
        issue_req(1'b1, 4'b1111, 30'h10, 8'h00);
        issue_req(1'b0, 4'b1111, 30'h10, 8'h5a);
        wait_pending(2);
        answer(0);
        answer(0);
        expect_rsp(4'b1111, 8'h5a, 30'h10, 1'b1);
        check_val("idle", idle, 1'b1);
    endtask

    task automatic batch_skip();
        req_log.delete();
        issue_req(1'b0, 4'b0011, 30'h20, 8'h21);
        wait_pending(1);
        repeat (6) @(negedge clk);
        check_val("mem request count", req_log.size(), 1);
        check_val("mem_req.tag.batch", req_log[0].tag.batch, 0);
        check_val("mem_req.mask", req_log[0].mask, 2'b11);
        answer(0);
        expect_rsp(4'b0011, 8'h21, 30'h20, 1'b0);
        req_log.delete();
        issue_req(1'b0, 4'b1100, 30'h28, 8'h22);
        wait_pending(1);
        repeat (6) @(negedge clk);
        check_val("mem request count", req_log.size(), 1);
        check_val("mem_req.tag.batch", req_log[0].tag.batch, 1);
        check_val("mem_req.mask", req_log[0].mask, 2'b11);
        answer(0);
        expect_rsp(4'b1100, 8'h22, 30'h28, 1'b0);
    endtask

    task automatic out_of_order();
        issue_req(1'b0, 4'b1111, 30'h30, 8'h11);
        issue_req(1'b0, 4'b1111, 30'h38, 8'h22);
        wait_pending(4);
        // Pending order is A0 A1 B0 B1
        answer(3);
        answer(0);
        answer(1);
        expect_rsp(4'b1111, 8'h22, 30'h38, 1'b0);
        answer(0);
        expect_rsp(4'b1111, 8'h11, 30'h30, 1'b0);
    endtask

    task automatic slot_exhaustion();
        for (int i = 0; i < QUEUE_SIZE; i++)
            issue_req(1'b0, 4'b1111, 30'h30 + 30'(4 * i), 8'h40 + 8'(i));
        present_req(make_req(1'b0, 4'b1111, 30'h20, 8'h55));
        repeat (8) begin
            @(posedge clk);
            check_val("core_req_ready", core_req_ready, 1'b0);
        end
        @(negedge clk);
        core_req_valid = 1'b0;
        issue_req(1'b1, 4'b1111, 30'h14, 8'h00);
        present_req(make_req(1'b0, 4'b1111, 30'h20, 8'h55));
        wait_pending(2);
        answer(0);
        answer(0);
        expect_rsp(4'b1111, 8'h40, 30'h30, 1'b0);
        await_req_accept();
        wait_pending(2 * QUEUE_SIZE);
        for (int i = 1; i < QUEUE_SIZE; i++) begin
            answer(0);
            answer(0);
            expect_rsp(4'b1111, 8'h40 + 8'(i), 30'h30 + 30'(4 * i), 1'b0);
        end
        answer(0);
        answer(0);
        expect_rsp(4'b1111, 8'h55, 30'h20, 1'b0);
    endtask

    task automatic back_pressure();
        @(negedge clk);
        core_rsp_ready = 1'b0;
        issue_req(1'b0, 4'b1111, 30'h08, 8'h77);
        wait_pending(2);
        answer(0);
        present_rsp(0);
        repeat (4) begin
            @(posedge clk);
            check_val("mem_rsp_ready", mem_rsp_ready, 1'b0);
        end
        @(negedge clk);
        check_val("core response count", rsp_log.size(), 0);
        check_val("idle", idle, 1'b0);
        core_rsp_ready = 1'b1;
        finish_rsp();
        expect_rsp(4'b1111, 8'h77, 30'h08, 1'b0);
        repeat (4) @(negedge clk);
        check_val("core response count", rsp_log.size(), 0);
        check_val("idle", idle, 1'b1);
    endtask

    initial begin
        for (int i = 0; i < 64; i++)
            mem_words[i] = fill_word(30'(i));
        clk            = 1'b0;
        reset          = 1'b1;
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b1;
        mem_req_ready  = 1'b0;
        mem_rsp_valid  = 1'b0;
        mem_rsp        = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        write_then_read();
        batch_skip();
        out_of_order();
        slot_exhaustion();
        back_pressure();
        if (UUT.protocol_chk.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

//--- mem_scheduler.f
hdl/core_side_pkg.sv
hdl/mem_side_pkg.sv
hdl/elastic_fifo.sv
hdl/tag_slot_table.sv
hdl/batch_sequencer.sv
hdl/rsp_assembler.sv
hdl/mem_scheduler.sv
bench/mem_scheduler_asserts.sv
bench/mem_scheduler_tb.sv

//--- Bender.yml
package:
  name: mem_scheduler

sources:
  - files:
      - hdl/core_side_pkg.sv
      - hdl/mem_side_pkg.sv
      - hdl/elastic_fifo.sv
      - hdl/tag_slot_table.sv
      - hdl/batch_sequencer.sv
      - hdl/rsp_assembler.sv
      - hdl/mem_scheduler.sv
  - target: test
    files:
      - bench/mem_scheduler_asserts.sv
      - bench/mem_scheduler_tb.sv
